// File: sim.f
+incdir+include
design/epd_pixel_pkg.sv
design/pixel_decode.sv
design/waveform_update.sv
design/mode_override.sv
design/pixel_pipe_top.sv
tb/tb_clock_gen.sv
tb/tb_pixel_pipe.sv

// File: include/epd_pixel_model.svh
// ********************************************************************
// Reference model of the full per-pixel rule for the testbench
// ********************************************************************
`ifndef EPD_PIXEL_MODEL_SVH
`define EPD_PIXEL_MODEL_SVH

// Expected state word and drive for one pixel
function automatic void model_pixel(
    input  epd_pixel_pkg::pixel_in_t    pix,
    input  epd_pixel_pkg::op_ctrl_t     op,
    input  logic [5:0]                  lutframe,
    input  logic [1:0]                  mindrv,
    input  logic [5:0]                  b2w_frames,
    input  logic [5:0]                  w2b_frames,
    output epd_pixel_pkg::pixel_state_t st,
    output epd_pixel_pkg::drive_t       drv
);
    epd_pixel_pkg::pixel_state_t bi;
    logic                        manual;
    logic                        setmode;
    logic                        clear;
    logic                        white;
    logic [3:0]                  vin;
    logic [5:0]                  full;
    bi      = pix.state;
    manual  = (bi.mode[3] == 1'b0);
    setmode = op.valid && (op.cmd == epd_pixel_pkg::OP_EXT_SETMODE);
    clear   = (op.valid && (op.cmd == epd_pixel_pkg::OP_EXT_REDRAW)) ||
              (setmode && (op.framecnt != 8'd0));
    // Input value after clear and dither choice
    if (clear)
        vin = (manual || !(op.framecnt[5] || (op.framecnt[4:3] == 2'b11))) ? 4'hF : 4'h0;
    else if (bi.mode[3:2] == epd_pixel_pkg::MODE_MANUAL_LUT_BLUE_NOISE)
        vin = pix.p_n4;
    else if (bi.mode == epd_pixel_pkg::MODE_FAST_MONO_BAYER)
        vin = {4{pix.p_bd}};
    else if (bi.mode == epd_pixel_pkg::MODE_FAST_MONO_BLUE_NOISE)
        vin = {4{pix.p_n1}};
    else
        vin = pix.p_or;
    white = vin[3];
    full  = white ? b2w_frames : w2b_frames;
    st    = bi;
    drv   = epd_pixel_pkg::NO_DRIVE;
    if (manual) begin
        if (bi.framecnt != 6'd0) begin
            drv         = pix.lut_rd;
            st.framecnt = bi.framecnt - 6'd1;
        end else if (clear) begin
            st = {bi.mode[3:2], bi.low, lutframe, vin};
        end
    end else if ((white != bi.low[0]) && ((bi.framecnt == 6'd0) || (bi.low[3:2] == 2'd0))) begin
        drv         = white ? epd_pixel_pkg::DRIVE_WHITE : epd_pixel_pkg::DRIVE_BLACK;
        st.framecnt = (bi.framecnt == 6'd0) ? full : (full - bi.framecnt + 6'd1);
        st.low      = {mindrv, 1'b0, white};
    end else if (bi.framecnt != 6'd0) begin
        drv         = bi.low[0] ? epd_pixel_pkg::DRIVE_WHITE : epd_pixel_pkg::DRIVE_BLACK;
        st.framecnt = bi.framecnt - 6'd1;
        st.low[3:2] = (bi.low[3:2] != 2'd0) ? (bi.low[3:2] - 2'd1) : 2'd0;
    end
    if (setmode && (op.framecnt == 8'd0)) begin
        case (op.param)
            8'd1:    st = epd_pixel_pkg::PRESET_MANUAL_BN;
            8'd2:    st = epd_pixel_pkg::PRESET_MONO_ND;
            8'd3:    st = epd_pixel_pkg::PRESET_MONO_BD;
            8'd4:    st = epd_pixel_pkg::PRESET_MONO_BN;
            default: st = epd_pixel_pkg::PRESET_MANUAL_ND;
        endcase
    end
    if (op.state == epd_pixel_pkg::OP_INIT) begin
        st  = epd_pixel_pkg::DEFAULT_STATE;
        drv = (op.framecnt[4:2] == 3'b111) ? epd_pixel_pkg::NO_DRIVE :
              op.framecnt[5] ? epd_pixel_pkg::DRIVE_BLACK : epd_pixel_pkg::DRIVE_WHITE;
    end
endfunction

`endif

// File: tb/tb_pixel_pipe.sv
// ********************************************************************
// Testbench for the pixel pipeline: LFSR stimulus, model queue,
// typed compare tasks, latency check and cycle limit
// ********************************************************************
`timescale 1ns/1ps
module tb_pixel_pipe;

    localparam int         NUM_SLOTS   = 600;
    localparam int         CYCLE_LIMIT = NUM_SLOTS + 20;
    localparam int         DRAIN_LIMIT = 8;
    localparam logic [5:0] LUTFRAME    = 6'd21;
    localparam logic [1:0] MINDRV      = 2'd2;
    localparam logic [5:0] MONO_FRAMES = 6'd9;

    logic                        clk;
    logic                        arst_n;
    logic                        in_valid;
    epd_pixel_pkg::pixel_in_t    pix;
    epd_pixel_pkg::op_ctrl_t     op;
    logic [5:0]                  csr_lutframe;
    logic [1:0]                  csr_mindrv;
    logic                        out_valid;
    epd_pixel_pkg::pixel_state_t state_out;
    epd_pixel_pkg::drive_t       drive;

    // Expected results in input order, with the cycle each pixel went in
    epd_pixel_pkg::pixel_state_t exp_state_q[$];
    epd_pixel_pkg::drive_t       exp_drive_q[$];
    int                          exp_cycle_q[$];

    logic [15:0]                 lfsr_q = 16'd6;
    int                          cycle;
    int                          state_errs;
    int                          drive_errs;
    int                          other_errs;
    epd_pixel_pkg::pixel_in_t    rnd_pix;
    epd_pixel_pkg::op_ctrl_t     rnd_op;
    epd_pixel_pkg::pixel_state_t exp_st;
    epd_pixel_pkg::drive_t       exp_drv;

    `include "epd_pixel_model.svh"

    tb_clock_gen tb_clock_gen_inst (
        .clk    (clk),
        .arst_n (arst_n)
    );

    pixel_pipe_top #(
        .FASTM_B2W_FRAMES (MONO_FRAMES),
        .FASTM_W2B_FRAMES (MONO_FRAMES)
    ) pixel_pipe_top_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .pix          (pix),
        .op           (op),
        .csr_lutframe (csr_lutframe),
        .csr_mindrv   (csr_mindrv),
        .out_valid    (out_valid),
        .state_out    (state_out),
        .drive        (drive)
    );

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Random pixel with a state word in one of the kept modes
    task automatic build_pixel(output epd_pixel_pkg::pixel_in_t p);
        logic [2:0] pick;
        logic [1:0] sub;
        logic [1:0] lut;
        pick = take_bits(3);
        case (pick)
            3'd0, 3'd1: begin
                sub          = take_bits(2);
                p.state.mode = {2'b00, sub};
            end
            3'd2: begin
                sub          = take_bits(2);
                p.state.mode = {2'b01, sub};
            end
            3'd5:       p.state.mode = epd_pixel_pkg::MODE_FAST_MONO_BAYER;
            3'd6, 3'd7: p.state.mode = epd_pixel_pkg::MODE_FAST_MONO_BLUE_NOISE;
            default:    p.state.mode = epd_pixel_pkg::MODE_FAST_MONO_NO_DITHER;
        endcase
        p.state.src_lo = take_bits(2);
        // Half the pixels idle, busy ones with a short count
        if (take_bits(1) == 1)
            p.state.framecnt = 6'd0;
        else
            p.state.framecnt = 6'd1 + take_bits(3);
        p.state.low = take_bits(4);
        p.p_or      = take_bits(4);
        p.p_bd      = take_bits(1);
        p.p_n1      = take_bits(1);
        p.p_n4      = take_bits(4);
        lut         = take_bits(2);
        // LUT read-out never holds the illegal code
        p.lut_rd    = (lut == 2'b11) ? epd_pixel_pkg::NO_DRIVE : epd_pixel_pkg::drive_t'(lut);
    endtask

    // Random op control, with redraw, set-mode and init all common
    task automatic build_op(output epd_pixel_pkg::op_ctrl_t o);
        logic [2:0] pick;
        pick    = take_bits(3);
        o.state = (pick == 3'd0) ? epd_pixel_pkg::OP_INIT :
                  (pick == 3'd1) ? epd_pixel_pkg::OP_IDLE : epd_pixel_pkg::OP_RUN;
        o.valid = (take_bits(3) != 0);
        pick    = take_bits(3);
        case (pick)
            3'd0, 3'd1: o.cmd = epd_pixel_pkg::OP_EXT_REDRAW;
            3'd2, 3'd3: o.cmd = epd_pixel_pkg::OP_EXT_SETMODE;
            3'd4:       o.cmd = take_bits(8);
            default:    o.cmd = 8'h00;
        endcase
        // Params 5 to 7 are invalid
        o.param = take_bits(3);
        if (take_bits(1) == 1)
            o.framecnt = 8'd0;
        else
            o.framecnt = take_bits(8);
    endtask

    task automatic check_state(input epd_pixel_pkg::pixel_state_t got,
                               input epd_pixel_pkg::pixel_state_t exp);
        if (got !== exp) begin
            state_errs++;
            $display("MISMATCH t=%0t state_out got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_drive(input epd_pixel_pkg::drive_t got,
                               input epd_pixel_pkg::drive_t exp);
        if (got !== exp) begin
            drive_errs++;
            $display("MISMATCH t=%0t drive got %b expected %b", $time, got, exp);
        end
    endtask

    // Pop and compare one result, also the 3-cycle latency
    task automatic collect_output();
        int in_cycle;
        if (out_valid === 1'b1) begin
            if (exp_state_q.size() == 0) begin
                other_errs++;
                $display("ERROR t=%0t out_valid with no pixel pending", $time);
            end else begin
                check_state(state_out, exp_state_q.pop_front());
                check_drive(drive, exp_drive_q.pop_front());
                in_cycle = exp_cycle_q.pop_front();
                if (cycle != in_cycle + 3) begin
                    other_errs++;
                    $display("ERROR t=%0t result came %0d cycles after its input",
                             $time, cycle - in_cycle);
                end
            end
        end
    endtask

    initial begin
        in_valid     <= 1'b0;
        pix          <= '0;
        op           <= '0;
        csr_lutframe <= LUTFRAME;
        csr_mindrv   <= MINDRV;
        cycle        = 0;
        state_errs   = 0;
        drive_errs   = 0;
        other_errs   = 0;
        wait (arst_n === 1'b1);
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            other_errs++;
            $display("ERROR t=%0t out_valid is not low after reset", $time);
        end
        check_drive(drive, epd_pixel_pkg::NO_DRIVE);
        // About one slot in four carries no pixel
        for (int slot = 0; slot < NUM_SLOTS; slot++) begin
            @(posedge clk);
            cycle++;
            if (take_bits(2) != 0) begin
                build_pixel(rnd_pix);
                build_op(rnd_op);
                model_pixel(rnd_pix, rnd_op, LUTFRAME, MINDRV, MONO_FRAMES, MONO_FRAMES,
                            exp_st, exp_drv);
                exp_state_q.push_back(exp_st);
                exp_drive_q.push_back(exp_drv);
                exp_cycle_q.push_back(cycle);
                in_valid <= 1'b1;
                pix      <= rnd_pix;
                op       <= rnd_op;
            end else begin
                in_valid <= 1'b0;
            end
            @(negedge clk);
            collect_output();
        end
        @(posedge clk);
        cycle++;
        in_valid <= 1'b0;
        @(negedge clk);
        collect_output();
        // Drain the pipe for a bounded time, then look for stray results
        for (int d = 0; (d < DRAIN_LIMIT) && (exp_state_q.size() != 0); d++) begin
            @(posedge clk);
            cycle++;
            @(negedge clk);
            collect_output();
        end
        repeat (5) begin
            @(posedge clk);
            cycle++;
            @(negedge clk);
            collect_output();
        end
        if (exp_state_q.size() != 0) begin
            other_errs++;
            $display("ERROR %0d expected results never came out", exp_state_q.size());
        end
        $display("errors: state %0d, drive %0d, other %0d", state_errs, drive_errs, other_errs);
        if ((state_errs + drive_errs + other_errs) == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog on total clock cycles
    initial begin
        repeat (CYCLE_LIMIT) @(posedge clk);
        $display("ERROR run stopped after %0d cycles without finishing", CYCLE_LIMIT);
        $display("errors: state %0d, drive %0d, other %0d", state_errs, drive_errs, other_errs);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: tb/tb_clock_gen.sv
// ********************************************************************
// Testbench clock, 100 ns period, and active-low reset for 2 cycles
// ********************************************************************
`timescale 1ns/1ps
module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Reset released on the second rising edge
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// File: design/pixel_pipe_top.sv
// ********************************************************************
// Three-stage pixel waveform pipeline, result 3 cycles after input
// ********************************************************************
`timescale 1ns/1ps
module pixel_pipe_top #(
    parameter logic [5:0] FASTM_B2W_FRAMES = 6'd9,
    parameter logic [5:0] FASTM_W2B_FRAMES = 6'd9
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        in_valid,
    input  epd_pixel_pkg::pixel_in_t    pix,
    input  epd_pixel_pkg::op_ctrl_t     op,
    input  logic [5:0]                  csr_lutframe,
    input  logic [1:0]                  csr_mindrv,
    output logic                        out_valid,
    output epd_pixel_pkg::pixel_state_t state_out,
    output epd_pixel_pkg::drive_t       drive
);

    logic                    dec_valid;
    epd_pixel_pkg::decoded_t dec;
    logic                    upd_valid;
    epd_pixel_pkg::updated_t upd;

    pixel_decode pixel_decode_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .pix       (pix),
        .op        (op),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    // Mono transition lengths in frames
    waveform_update #(
        .FASTM_B2W_FRAMES (FASTM_B2W_FRAMES),
        .FASTM_W2B_FRAMES (FASTM_W2B_FRAMES)
    ) waveform_update_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .dec_valid    (dec_valid),
        .dec          (dec),
        .csr_lutframe (csr_lutframe),
        .csr_mindrv   (csr_mindrv),
        .upd_valid    (upd_valid),
        .upd          (upd)
    );

    mode_override mode_override_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .upd_valid (upd_valid),
        .upd       (upd),
        .out_valid (out_valid),
        .state_out (state_out),
        .drive     (drive)
    );

endmodule

// File: design/mode_override.sv
// ********************************************************************
// Stage 3: set-mode presets and init drive pattern
// ********************************************************************
`timescale 1ns/1ps
module mode_override (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        upd_valid,
    input  epd_pixel_pkg::updated_t     upd,
    output logic                        out_valid,
    output epd_pixel_pkg::pixel_state_t state_out,
    output epd_pixel_pkg::drive_t       drive
);

    epd_pixel_pkg::pixel_state_t state_d;
    epd_pixel_pkg::drive_t       drive_d;

    always_comb begin
        state_d = upd.state_next;
        drive_d = upd.drive;
        if (upd.set_mode_apply) begin
            case (upd.param)
                epd_pixel_pkg::SETMODE_MANUAL_LUT_BLUE_NOISE:
                    state_d = epd_pixel_pkg::PRESET_MANUAL_BN;
                epd_pixel_pkg::SETMODE_FAST_MONO_NO_DITHER:
                    state_d = epd_pixel_pkg::PRESET_MONO_ND;
                epd_pixel_pkg::SETMODE_FAST_MONO_BAYER:
                    state_d = epd_pixel_pkg::PRESET_MONO_BD;
                epd_pixel_pkg::SETMODE_FAST_MONO_BLUE_NOISE:
                    state_d = epd_pixel_pkg::PRESET_MONO_BN;
                // Manual no-dither, also taken for an invalid parameter
                default:
                    state_d = epd_pixel_pkg::PRESET_MANUAL_ND;
            endcase
        end
        // Init wins over everything
        // Frame bits 4-2 all set is the no-op window, bit 5 picks black
        if (upd.init_active) begin
            state_d = epd_pixel_pkg::DEFAULT_STATE;
            if (upd.init_frame[2:0] == 3'b111) begin
                drive_d = epd_pixel_pkg::NO_DRIVE;
            end else if (upd.init_frame[3]) begin
                drive_d = epd_pixel_pkg::DRIVE_BLACK;
            end else begin
                drive_d = epd_pixel_pkg::DRIVE_WHITE;
            end
        end
    end

    // Panel sees no drive until the first result
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            drive     <= epd_pixel_pkg::NO_DRIVE;
        end else begin
            out_valid <= upd_valid;
            if (upd_valid) begin
                drive <= drive_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid) begin
            state_out <= state_d;
        end
    end

    // A result handed to the panel is fully known
    a_out_known: assert property (
        @(posedge clk) disable iff (!arst_n) out_valid |-> !$isunknown({state_out, drive})
    );

endmodule

// File: design/waveform_update.sv
// ********************************************************************
// Stage 2: next state and drive code for manual LUT and fast mono
// ********************************************************************
`timescale 1ns/1ps
module waveform_update #(
    parameter logic [5:0] FASTM_B2W_FRAMES = 6'd9,
    parameter logic [5:0] FASTM_W2B_FRAMES = 6'd9
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    dec_valid,
    input  epd_pixel_pkg::decoded_t dec,
    input  logic [5:0]              csr_lutframe,
    input  logic [1:0]              csr_mindrv,
    output logic                    upd_valid,
    output epd_pixel_pkg::updated_t upd
);

    epd_pixel_pkg::pixel_state_t st;
    epd_pixel_pkg::pixel_state_t st_next;
    epd_pixel_pkg::drive_t       drive_next;
    epd_pixel_pkg::drive_t       drive_toward;
    epd_pixel_pkg::drive_t       drive_hold;
    logic                        to_white;
    logic                        prev;
    logic [1:0]                  mindrv;
    logic [1:0]                  mindrv_dec;
    logic [5:0]                  framecnt_dec;
    logic [5:0]                  full_cnt;
    logic [5:0]                  reverse_cnt;

    assign st       = dec.state;
    assign to_white = dec.vin[3];
    // Fast mono fields of the low nibble
    assign prev     = st.low[0];
    assign mindrv   = st.low[3:2];

    assign framecnt_dec = st.framecnt - 6'd1;
    // Frame rate cap counts down and stops at zero
    assign mindrv_dec   = (mindrv != 2'd0) ? (mindrv - 2'd1) : 2'd0;
    assign full_cnt     = to_white ? FASTM_B2W_FRAMES : FASTM_W2B_FRAMES;
    // A reversal mid-drive only has to undo the frames already spent
    assign reverse_cnt  = full_cnt - st.framecnt + 6'd1;

    assign drive_toward = to_white ? epd_pixel_pkg::DRIVE_WHITE : epd_pixel_pkg::DRIVE_BLACK;
    assign drive_hold   = prev ? epd_pixel_pkg::DRIVE_WHITE : epd_pixel_pkg::DRIVE_BLACK;

    always_comb begin
        st_next    = st;
        drive_next = epd_pixel_pkg::NO_DRIVE;
        case (dec.base_mode)
            epd_pixel_pkg::MANUAL_LUT: begin
                if (st.framecnt != 6'd0) begin
                    // LUT in progress, source and target held
                    drive_next       = dec.lut_rd;
                    st_next.framecnt = framecnt_dec;
                end else if (dec.update_req) begin
                    // Old target becomes source, fresh LUT run toward vin
                    st_next = {st.mode[3:2], st.low, csr_lutframe, dec.vin};
                end
            end
            default: begin
                // Fast mono
                if (st.framecnt == 6'd0) begin
                    if (to_white != prev) begin
                        drive_next       = drive_toward;
                        st_next.framecnt = full_cnt;
                        st_next.low      = {csr_mindrv, 1'b0, to_white};
                    end
                end else if ((to_white != prev) && (mindrv == 2'd0)) begin
                    drive_next       = drive_toward;
                    st_next.framecnt = reverse_cnt;
                    st_next.low      = {csr_mindrv, 1'b0, to_white};
                end else begin
                    // Keep driving the current colour
                    drive_next         = drive_hold;
                    st_next.framecnt   = framecnt_dec;
                    st_next.low[3:2]   = mindrv_dec;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            upd_valid <= 1'b0;
        end else begin
            upd_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            upd.state_next     <= st_next;
            upd.drive          <= drive_next;
            upd.set_mode_apply <= dec.set_mode_apply;
            upd.param          <= dec.param;
            upd.init_active    <= dec.init_active;
            upd.init_frame     <= dec.init_frame;
        end
    end

    a_drive_legal: assert property (
        @(posedge clk) disable iff (!arst_n) upd_valid |-> (upd.drive != 2'b11)
    );

endmodule

// File: design/pixel_decode.sv
// ********************************************************************
// Stage 1: mode and command decode, clear colour, dither selection
// ********************************************************************
`timescale 1ns/1ps
module pixel_decode (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  epd_pixel_pkg::pixel_in_t pix,
    input  epd_pixel_pkg::op_ctrl_t  op,
    output logic                    dec_valid,
    output epd_pixel_pkg::decoded_t  dec
);

    epd_pixel_pkg::base_mode_t base_mode;
    epd_pixel_pkg::dither_t    dither;
    logic                      redraw_en;
    logic                      set_mode_en;
    logic                      force_clear;
    logic [3:0]                clear_color;
    logic [3:0]                vin;

    // Mode field to base mode and dither kind
    always_comb begin
        base_mode = epd_pixel_pkg::FAST_MONO;
        dither    = epd_pixel_pkg::NONE;
        if (pix.state.mode[3:2] == epd_pixel_pkg::MODE_MANUAL_LUT_NO_DITHER) begin
            base_mode = epd_pixel_pkg::MANUAL_LUT;
        end else if (pix.state.mode[3:2] == epd_pixel_pkg::MODE_MANUAL_LUT_BLUE_NOISE) begin
            base_mode = epd_pixel_pkg::MANUAL_LUT;
            dither    = epd_pixel_pkg::BN_4BIT;
        end else begin
            // Unknown and dropped modes fall back to mono without dither
            case (pix.state.mode)
                epd_pixel_pkg::MODE_FAST_MONO_BAYER:      dither = epd_pixel_pkg::BAYER;
                epd_pixel_pkg::MODE_FAST_MONO_BLUE_NOISE: dither = epd_pixel_pkg::BN_1BIT;
                default:                                  dither = epd_pixel_pkg::NONE;
            endcase
        end
    end

    // Command decode
    assign redraw_en   = op.valid && (op.cmd == epd_pixel_pkg::OP_EXT_REDRAW);
    assign set_mode_en = op.valid && (op.cmd == epd_pixel_pkg::OP_EXT_SETMODE);
    // Set-mode outside frame zero only clears the pixel
    assign force_clear = redraw_en || (set_mode_en && (op.framecnt != 8'd0));

    // Manual clears to white, mono alternates with the global frame count
    assign clear_color = (base_mode == epd_pixel_pkg::MANUAL_LUT) ? 4'hF :
                         ((op.framecnt[4:3] == 2'b11) || op.framecnt[5]) ? 4'h0 : 4'hF;

    always_comb begin
        if (force_clear) begin
            vin = clear_color;
        end else begin
            case (dither)
                epd_pixel_pkg::BAYER:   vin = {4{pix.p_bd}};
                epd_pixel_pkg::BN_1BIT: vin = {4{pix.p_n1}};
                epd_pixel_pkg::BN_4BIT: vin = pix.p_n4;
                default:                vin = pix.p_or;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    // Payload loads only with a valid pixel
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec.state          <= pix.state;
            dec.base_mode      <= base_mode;
            dec.vin            <= vin;
            dec.lut_rd         <= pix.lut_rd;
            // Any forced clear restarts an idle manual pixel
            dec.update_req     <= force_clear;
            dec.set_mode_apply <= set_mode_en && (op.framecnt == 8'd0);
            dec.param          <= op.param;
            dec.init_active    <= (op.state == epd_pixel_pkg::OP_INIT);
            dec.init_frame     <= op.framecnt[5:2];
        end
    end

    a_dec_valid_known: assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(dec_valid)
    );

endmodule

// File: design/epd_pixel_pkg.sv
// ********************************************************************
// Shared types for the e-paper pixel pipeline: state word, mode and
// drive encodings, command and preset constants, stage structs
// ********************************************************************
package epd_pixel_pkg;

    // VRAM state word
    // Manual LUT source value is {mode[1:0], src_lo}, sharing mode bits 13-12
    // Fast mono low nibble: mindrv 3-2, reserved 1, previous colour 0
    typedef struct packed {
        logic [3:0] mode;
        logic [1:0] src_lo;
        logic [5:0] framecnt;
        logic [3:0] low;
    } pixel_state_t;

    // Manual modes match on mode[3:2] only
    localparam logic [1:0] MODE_MANUAL_LUT_NO_DITHER  = 2'd0;
    localparam logic [1:0] MODE_MANUAL_LUT_BLUE_NOISE = 2'd1;
    localparam logic [3:0] MODE_FAST_MONO_NO_DITHER   = 4'd8;
    localparam logic [3:0] MODE_FAST_MONO_BAYER       = 4'd9;
    localparam logic [3:0] MODE_FAST_MONO_BLUE_NOISE  = 4'd10;

    typedef enum logic [1:0] {
        MANUAL_LUT = 2'b00,
        FAST_MONO  = 2'b01
    } base_mode_t;

    typedef enum logic [2:0] {
        NONE    = 3'b000,
        BAYER   = 3'b001,
        BN_1BIT = 3'b010,
        BN_4BIT = 3'b011
    } dither_t;

    // Panel drive code, 2'b11 is never issued
    typedef enum logic [1:0] {
        NO_DRIVE    = 2'b00,
        DRIVE_BLACK = 2'b01,
        DRIVE_WHITE = 2'b10
    } drive_t;

    typedef enum logic [1:0] {
        OP_IDLE = 2'd0,
        OP_INIT = 2'd1,
        OP_RUN  = 2'd2
    } op_state_t;

    // External commands
    localparam logic [7:0] OP_EXT_REDRAW  = 8'h01;
    localparam logic [7:0] OP_EXT_SETMODE = 8'h02;

    // Set-mode parameter values
    localparam logic [7:0] SETMODE_MANUAL_LUT_NO_DITHER  = 8'd0;
    localparam logic [7:0] SETMODE_MANUAL_LUT_BLUE_NOISE = 8'd1;
    localparam logic [7:0] SETMODE_FAST_MONO_NO_DITHER   = 8'd2;
    localparam logic [7:0] SETMODE_FAST_MONO_BAYER       = 8'd3;
    localparam logic [7:0] SETMODE_FAST_MONO_BLUE_NOISE  = 8'd4;

    // Presets: mode, zero src, zero framecnt, low nibble all ones
    localparam pixel_state_t PRESET_MANUAL_ND =
        {MODE_MANUAL_LUT_NO_DITHER, 2'b00, 2'b00, 6'd0, 4'hF};
    localparam pixel_state_t PRESET_MANUAL_BN =
        {MODE_MANUAL_LUT_BLUE_NOISE, 2'b00, 2'b00, 6'd0, 4'hF};
    localparam pixel_state_t PRESET_MONO_ND = {MODE_FAST_MONO_NO_DITHER, 2'b00, 6'd0, 4'hF};
    localparam pixel_state_t PRESET_MONO_BD = {MODE_FAST_MONO_BAYER, 2'b00, 6'd0, 4'hF};
    localparam pixel_state_t PRESET_MONO_BN = {MODE_FAST_MONO_BLUE_NOISE, 2'b00, 6'd0, 4'hF};
    localparam pixel_state_t DEFAULT_STATE  = PRESET_MONO_ND;

    // Per-pixel input: dithered source forms, LUT read-out, VRAM word
    typedef struct packed {
        logic [3:0]   p_or;
        logic         p_bd;
        logic         p_n1;
        logic [3:0]   p_n4;
        drive_t       lut_rd;
        pixel_state_t state;
    } pixel_in_t;

    // Global operation control
    typedef struct packed {
        op_state_t  state;
        logic       valid;
        logic [7:0] cmd;
        logic [7:0] param;
        logic [7:0] framecnt;
    } op_ctrl_t;

    // Stage 1 to stage 2
    typedef struct packed {
        pixel_state_t state;
        base_mode_t   base_mode;
        logic [3:0]   vin;
        drive_t       lut_rd;
        logic         update_req;
        logic         set_mode_apply;
        logic [7:0]   param;
        logic         init_active;
        logic [3:0]   init_frame;
    } decoded_t;

    // Stage 2 to stage 3
    typedef struct packed {
        pixel_state_t state_next;
        drive_t       drive;
        logic         set_mode_apply;
        logic [7:0]   param;
        logic         init_active;
        logic [3:0]   init_frame;
    } updated_t;

endpackage
